//--- list.f
+incdir+.
yolo_cfg_pkg.sv
yolo_mem_pkg.sv
yolo_cfg_regs.sv
stage_addr_gen.sv
cfg_shadow.sv
dma_len_ctrl.sv
yolo_write_ctrl.sv
tb_yolo_write_ctrl.sv

//--- Bender.yml
package:
  name: yolo_write_ctrl

export_include_dirs:
  - .

sources:
  - yolo_cfg_pkg.sv
  - yolo_mem_pkg.sv
  - yolo_cfg_regs.sv
  - stage_addr_gen.sv
  - cfg_shadow.sv
  - dma_len_ctrl.sv
  - yolo_write_ctrl.sv
  - target: test
    files:
      - tb_yolo_write_ctrl.sv

//--- tb_yolo_write_ctrl.sv
`timescale 1ns/1ps
`include "yolo_write_settings.svh"

module tb_yolo_write_ctrl
   import yolo_cfg_pkg::*;
   import yolo_mem_pkg::*;
();

   localparam int N_ROWS = 11;
   localparam int MAX_WR = 11;
   localparam int W = `IO_ADDR_W;
   localparam int RD_MSB = `VREAD_INT_W - 1;
   localparam int WR_MSB = `VWRITE_INT_W - 1;

   logic clk, rst, clear, run, valid, wstrb, rd_ready;
   cfg_addr_t addr;
   io_addr_t wdata;
   stage_addr_bus_t vread_stage_addr, vwrite_stage_addr;
   vread_int_t vread_int_addr;
   vwrite_int_t vwrite_int_addr;
   iter_t vread_iter_a, vwrite_iter_a;
   axi_len_t dma_len_rd, dma_len_wr;

   // stimulus table
   string     t_name [N_ROWS];
   int        t_n_wr [N_ROWS];
   cfg_addr_t t_wr_addr [N_ROWS][MAX_WR];
   io_addr_t  t_wr_data [N_ROWS][MAX_WR];
   logic      t_clear [N_ROWS];
   int        t_runs [N_ROWS];
   int        t_ready [N_ROWS];

   // expected outputs per row
   stage_addr_bus_t e_rd_stage [N_ROWS];
   stage_addr_bus_t e_wr_stage [N_ROWS];
   vread_int_t      e_rd_int [N_ROWS];
   vwrite_int_t     e_wr_int [N_ROWS];
   iter_t           e_rd_iter [N_ROWS];
   iter_t           e_wr_iter [N_ROWS];
   axi_len_t        e_len_rd [N_ROWS];
   axi_len_t        e_len_wr [N_ROWS];

   // reference model state for live registers and shadows
   io_addr_t    m_rd_ext, m_wr_ext;
   io_half_t    m_rd_off, m_wr_off, m_rd_len;
   logic        m_rd_pp;
   axi_len_t    m_wr_len;
   vread_int_t  m_rd_int;
   vwrite_int_t m_wr_int;
   iter_t       m_rd_iter, m_wr_iter;
   stage_addr_bus_t s_rd_stage;
   io_half_t    s_rd_len;
   vread_int_t  s_rd_int;
   iter_t       s_rd_iter;
   // vwrite pipeline where index 0 is pip0 and 2 is the shadow
   stage_addr_bus_t p_wr_stage [3];
   axi_len_t    p_wr_len [3];
   vwrite_int_t p_wr_int [3];
   iter_t       p_wr_iter [3];
   io_half_t    m_cnt;

   int n_checks = 0;
   int n_errors = 0;
   int cycles = 0;
   int cycle_limit = 0;

   yolo_write_ctrl u_yolo_write_ctrl (
      .clk               (clk),
      .rst               (rst),
      .clear             (clear),
      .run               (run),
      .valid             (valid),
      .addr              (addr),
      .wdata             (wdata),
      .wstrb             (wstrb),
      .rd_ready          (rd_ready),
      .vread_stage_addr  (vread_stage_addr),
      .vread_int_addr    (vread_int_addr),
      .vread_iter_a      (vread_iter_a),
      .vwrite_stage_addr (vwrite_stage_addr),
      .vwrite_int_addr   (vwrite_int_addr),
      .vwrite_iter_a     (vwrite_iter_a),
      .dma_len_rd        (dma_len_rd),
      .dma_len_wr        (dma_len_wr)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAIL");
         $finish;
      end
   end

   // stage i is base plus i times offset modulo the bus width
   function automatic stage_addr_bus_t expect_stages(input io_addr_t base, input io_half_t off);
      stage_addr_bus_t r;
      for (int i = 0; i < `N_STAGES; i++) begin
         r[i*W +: W] = base + io_addr_t'(i) * io_addr_t'(off);
      end
      return r;
   endfunction

   function automatic void model_write(input cfg_addr_t a, input io_addr_t d);
      case (a)
         `REG_VREAD_EXT_ADDR:  m_rd_ext = d;
         `REG_VREAD_OFFSET:    m_rd_off = d[15:0];
         `REG_VREAD_PP:        m_rd_pp = d[0];
         `REG_VREAD_LEN:       m_rd_len = d[15:0];
         `REG_VREAD_INT_ADDR:  m_rd_int = d[RD_MSB:0];
         `REG_VREAD_ITER_A:    m_rd_iter = d[`ITER_W-1:0];
         `REG_VWRITE_EXT_ADDR: m_wr_ext = d;
         `REG_VWRITE_OFFSET:   m_wr_off = d[15:0];
         `REG_VWRITE_LEN:      m_wr_len = d[`AXI_LEN_W-1:0];
         `REG_VWRITE_INT_ADDR: m_wr_int = d[WR_MSB:0];
         `REG_VWRITE_ITER_A:   m_wr_iter = d[`ITER_W-1:0];
         default: ;
      endcase
   endfunction

   function automatic void model_clear();
      m_rd_ext = '0;
      m_wr_ext = '0;
      m_rd_off = '0;
      m_wr_off = '0;
      m_rd_len = '0;
      m_rd_pp = 1'b0;
      m_wr_len = '0;
      m_rd_int = '0;
      m_wr_int = '0;
      m_rd_iter = '0;
      m_wr_iter = '0;
   endfunction

   function automatic void model_run();
      logic wr_top;
      wr_top = p_wr_int[0][WR_MSB] ^ (p_wr_iter[0] != 0);
      s_rd_stage = expect_stages(m_rd_ext, m_rd_off);
      s_rd_len = m_rd_len;
      s_rd_iter = m_rd_iter;
      if (m_rd_pp) begin
         s_rd_int = {s_rd_int[RD_MSB] ^ (m_rd_iter != 0), m_rd_int[RD_MSB-1:0]};
      end else begin
         s_rd_int = m_rd_int;
      end
      for (int k = 2; k > 0; k--) begin
         p_wr_stage[k] = p_wr_stage[k-1];
         p_wr_len[k] = p_wr_len[k-1];
         p_wr_int[k] = p_wr_int[k-1];
         p_wr_iter[k] = p_wr_iter[k-1];
      end
      p_wr_stage[0] = expect_stages(m_wr_ext, m_wr_off);
      p_wr_len[0] = m_wr_len;
      p_wr_int[0] = {wr_top, m_wr_int[WR_MSB-1:0]};
      p_wr_iter[0] = m_wr_iter;
      m_cnt = m_rd_len;
   endfunction

   function automatic void model_ready();
      m_cnt = (m_cnt == 0) ? s_rd_len : m_cnt - 1'b1;
   endfunction

   function automatic void add_write(input int r, input cfg_addr_t a, input io_addr_t d);
      t_wr_addr[r][t_n_wr[r]] = a;
      t_wr_data[r][t_n_wr[r]] = d;
      t_n_wr[r]++;
   endfunction

   function automatic void set_row(input int r, input string name, input logic clr,
                                   input int runs, input int ready);
      t_name[r] = name;
      t_clear[r] = clr;
      t_runs[r] = runs;
      t_ready[r] = ready;
   endfunction

   task automatic build_table();
      int len_big;
      int left;
      int back;
      for (int r = 0; r < N_ROWS; r++) begin
         t_n_wr[r] = 0;
      end
      set_row(0, "basic", 1'b0, 1, 0);
      add_write(0, `REG_VREAD_EXT_ADDR, $urandom);
      add_write(0, `REG_VREAD_OFFSET, $urandom);
      add_write(0, `REG_VREAD_PP, 0);
      add_write(0, `REG_VREAD_LEN, $urandom_range(200, 1));
      add_write(0, `REG_VREAD_INT_ADDR, $urandom & 32'h1ff);
      add_write(0, `REG_VREAD_ITER_A, $urandom);
      add_write(0, `REG_VWRITE_EXT_ADDR, $urandom);
      add_write(0, `REG_VWRITE_OFFSET, $urandom);
      add_write(0, `REG_VWRITE_LEN, $urandom);
      add_write(0, `REG_VWRITE_INT_ADDR, $urandom);
      add_write(0, `REG_VWRITE_ITER_A, $urandom_range(2047, 1));
      set_row(1, "pp_toggle", 1'b0, 3, 0);
      add_write(1, `REG_VREAD_PP, 1);
      add_write(1, `REG_VREAD_ITER_A, $urandom_range(2047, 1));
      set_row(2, "pp_off", 1'b0, 1, 0);
      add_write(2, `REG_VREAD_PP, 0);
      add_write(2, `REG_VREAD_INT_ADDR, $urandom | 32'h200);
      set_row(3, "wr_pipe_run0", 1'b0, 1, 0);
      add_write(3, `REG_VWRITE_EXT_ADDR, $urandom);
      add_write(3, `REG_VWRITE_OFFSET, $urandom);
      add_write(3, `REG_VWRITE_LEN, $urandom);
      add_write(3, `REG_VWRITE_INT_ADDR, $urandom);
      add_write(3, `REG_VWRITE_ITER_A, $urandom_range(2047, 1));
      set_row(4, "wr_pipe_run1", 1'b0, 1, 0);
      set_row(5, "wr_pipe_run2", 1'b0, 1, 0);
      set_row(6, "clear_run", 1'b1, 1, 0);
      set_row(7, "clear_flush", 1'b0, 2, 0);
      // long read burst counted down to zero and reloaded from the shadow
      len_big = $urandom_range(1000, 300);
      left = $urandom_range(250, 10);
      back = $urandom_range(250, 10);
      set_row(8, "dma_sat", 1'b0, 1, 0);
      add_write(8, `REG_VREAD_LEN, len_big);
      set_row(9, "dma_count", 1'b0, 0, len_big - left);
      // live length above any shadow value so a reload from it shows
      set_row(10, "dma_reload", 1'b0, 0, left + 1 + len_big - back);
      add_write(10, `REG_VREAD_LEN, $urandom_range(2000, 1001));
   endtask

   task automatic build_expected();
      model_clear();
      s_rd_stage = '0;
      s_rd_len = '0;
      s_rd_int = '0;
      s_rd_iter = '0;
      m_cnt = '0;
      for (int k = 0; k < 3; k++) begin
         p_wr_stage[k] = '0;
         p_wr_len[k] = '0;
         p_wr_int[k] = '0;
         p_wr_iter[k] = '0;
      end
      cycle_limit = 8 + 10;
      for (int r = 0; r < N_ROWS; r++) begin
         for (int k = 0; k < t_n_wr[r]; k++) begin
            model_write(t_wr_addr[r][k], t_wr_data[r][k]);
         end
         if (t_clear[r]) begin
            model_clear();
         end
         repeat (t_runs[r]) model_run();
         repeat (t_ready[r]) model_ready();
         e_rd_stage[r] = s_rd_stage;
         e_rd_int[r] = s_rd_int;
         e_rd_iter[r] = s_rd_iter;
         e_wr_stage[r] = p_wr_stage[2];
         e_wr_int[r] = p_wr_int[2];
         e_wr_iter[r] = p_wr_iter[2];
         e_len_wr[r] = p_wr_len[2];
         e_len_rd[r] = (m_cnt >= (1 << `AXI_LEN_W)) ? '1 : m_cnt[`AXI_LEN_W-1:0];
         cycle_limit += t_n_wr[r] + `MUL_LAT + 3 * t_runs[r] + t_ready[r] + 10;
      end
   endtask

   task automatic compare(input string name, input stage_addr_bus_t exp,
                          input stage_addr_bus_t act);
      n_checks++;
      if (exp !== act) begin
         n_errors++;
         $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
      end
   endtask

   task automatic check_row(input int r);
      compare({t_name[r], " vread_stage_addr"}, e_rd_stage[r], vread_stage_addr);
      compare({t_name[r], " vread_int_addr"}, e_rd_int[r], vread_int_addr);
      compare({t_name[r], " vread_iter_a"}, e_rd_iter[r], vread_iter_a);
      compare({t_name[r], " vwrite_stage_addr"}, e_wr_stage[r], vwrite_stage_addr);
      compare({t_name[r], " vwrite_int_addr"}, e_wr_int[r], vwrite_int_addr);
      compare({t_name[r], " vwrite_iter_a"}, e_wr_iter[r], vwrite_iter_a);
      compare({t_name[r], " dma_len_rd"}, e_len_rd[r], dma_len_rd);
      compare({t_name[r], " dma_len_wr"}, e_len_wr[r], dma_len_wr);
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      clear = 1'b0;
      run = 1'b0;
      valid = 1'b0;
      wstrb = 1'b0;
      rd_ready = 1'b0;
      addr = '0;
      wdata = '0;
      void'($urandom(32'hbe1d));
      build_table();
      build_expected();
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int r = 0; r < N_ROWS; r++) begin
         for (int k = 0; k < t_n_wr[r]; k++) begin
            @(negedge clk);
            valid = 1'b1;
            wstrb = 1'b1;
            addr = t_wr_addr[r][k];
            wdata = t_wr_data[r][k];
         end
         @(negedge clk);
         valid = 1'b0;
         wstrb = 1'b0;
         if (t_clear[r]) begin
            clear = 1'b1;
            @(negedge clk);
            clear = 1'b0;
         end
         // let the stage address pipelines settle
         repeat (`MUL_LAT + 2) @(negedge clk);
         repeat (t_runs[r]) begin
            run = 1'b1;
            @(negedge clk);
            run = 1'b0;
            repeat (2) @(negedge clk);
         end
         if (t_ready[r] > 0) begin
            rd_ready = 1'b1;
            repeat (t_ready[r]) @(negedge clk);
            rd_ready = 1'b0;
         end
         check_row(r);
      end
      $display("checks %0d errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- yolo_write_ctrl.sv
`timescale 1ns/1ps

module yolo_write_ctrl
   import yolo_cfg_pkg::*;
   import yolo_mem_pkg::*;
(
   input  logic            clk,
   input  logic            rst,
   input  logic            clear,
   input  logic            run,
   input  logic            valid,
   input  cfg_addr_t       addr,
   input  io_addr_t        wdata,
   input  logic            wstrb,
   input  logic            rd_ready,
   output stage_addr_bus_t vread_stage_addr,
   output vread_int_t      vread_int_addr,
   output iter_t           vread_iter_a,
   output stage_addr_bus_t vwrite_stage_addr,
   output vwrite_int_t     vwrite_int_addr,
   output iter_t           vwrite_iter_a,
   output axi_len_t        dma_len_rd,
   output axi_len_t        dma_len_wr
);

   // live configuration
   io_addr_t        cfg_rd_ext_addr, cfg_wr_ext_addr;
   io_half_t        cfg_rd_offset, cfg_wr_offset;
   logic            cfg_rd_pp;
   io_half_t        cfg_rd_len;
   axi_len_t        cfg_wr_len;
   vread_int_t      cfg_rd_int_addr;
   vwrite_int_t     cfg_wr_int_addr;
   iter_t           cfg_rd_iter_a, cfg_wr_iter_a;

   stage_addr_bus_t rd_stage_addr, wr_stage_addr;
   io_half_t        rd_len_sh;

   yolo_cfg_regs u_cfg_regs (
      .clk             (clk),
      .rst             (rst),
      .clear           (clear),
      .valid           (valid),
      .addr            (addr),
      .wdata           (wdata),
      .wstrb           (wstrb),
      .vread_ext_addr  (cfg_rd_ext_addr),
      .vread_offset    (cfg_rd_offset),
      .vread_pp        (cfg_rd_pp),
      .vread_len       (cfg_rd_len),
      .vread_int_addr  (cfg_rd_int_addr),
      .vread_iter_a    (cfg_rd_iter_a),
      .vwrite_ext_addr (cfg_wr_ext_addr),
      .vwrite_offset   (cfg_wr_offset),
      .vwrite_len      (cfg_wr_len),
      .vwrite_int_addr (cfg_wr_int_addr),
      .vwrite_iter_a   (cfg_wr_iter_a)
   );

   stage_addr_gen u_rd_addr (
      .clk        (clk),
      .rst        (rst),
      .base       (cfg_rd_ext_addr),
      .offset     (cfg_rd_offset),
      .stage_addr (rd_stage_addr)
   );

   stage_addr_gen u_wr_addr (
      .clk        (clk),
      .rst        (rst),
      .base       (cfg_wr_ext_addr),
      .offset     (cfg_wr_offset),
      .stage_addr (wr_stage_addr)
   );

   cfg_shadow u_cfg_shadow (
      .clk              (clk),
      .rst              (rst),
      .run              (run),
      .rd_stage_addr    (rd_stage_addr),
      .rd_pp            (cfg_rd_pp),
      .rd_len           (cfg_rd_len),
      .rd_int_addr      (cfg_rd_int_addr),
      .rd_iter_a        (cfg_rd_iter_a),
      .wr_stage_addr    (wr_stage_addr),
      .wr_len           (cfg_wr_len),
      .wr_int_addr      (cfg_wr_int_addr),
      .wr_iter_a        (cfg_wr_iter_a),
      .rd_stage_addr_sh (vread_stage_addr),
      .rd_len_sh        (rd_len_sh),
      .rd_int_addr_sh   (vread_int_addr),
      .rd_iter_a_sh     (vread_iter_a),
      .wr_stage_addr_sh (vwrite_stage_addr),
      .wr_len_sh        (dma_len_wr),
      .wr_int_addr_sh   (vwrite_int_addr),
      .wr_iter_a_sh     (vwrite_iter_a)
   );

   // counter loads the live length on run, reloads the shadow afterwards
   dma_len_ctrl u_dma_len (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .rd_ready   (rd_ready),
      .len        (cfg_rd_len),
      .len_sh     (rd_len_sh),
      .dma_len_rd (dma_len_rd)
   );

endmodule

//--- dma_len_ctrl.sv
`timescale 1ns/1ps

module dma_len_ctrl
   import yolo_mem_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     run,
   input  logic     rd_ready,
   input  io_half_t len,
   input  io_half_t len_sh,
   output axi_len_t dma_len_rd
);

   localparam int CNT_W = $bits(io_half_t);
   localparam int LEN_W = $bits(axi_len_t);

   // remaining read transfers
   io_half_t cnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cnt <= '0;
      end else if (run) begin
         cnt <= len;
      end else if (rd_ready) begin
         if (cnt == '0) begin
            cnt <= len_sh;
         end else begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   // clamp to the widest burst the axi length field holds
   assign dma_len_rd = (|cnt[CNT_W-1:LEN_W]) ? '1 : cnt[LEN_W-1:0];

endmodule

//--- cfg_shadow.sv
`timescale 1ns/1ps

module cfg_shadow
   import yolo_cfg_pkg::*;
   import yolo_mem_pkg::*;
(
   input  logic            clk,
   input  logic            rst,
   input  logic            run,
   input  stage_addr_bus_t rd_stage_addr,
   input  logic            rd_pp,
   input  io_half_t        rd_len,
   input  vread_int_t      rd_int_addr,
   input  iter_t           rd_iter_a,
   input  stage_addr_bus_t wr_stage_addr,
   input  axi_len_t        wr_len,
   input  vwrite_int_t     wr_int_addr,
   input  iter_t           wr_iter_a,
   output stage_addr_bus_t rd_stage_addr_sh,
   output io_half_t        rd_len_sh,
   output vread_int_t      rd_int_addr_sh,
   output iter_t           rd_iter_a_sh,
   output stage_addr_bus_t wr_stage_addr_sh,
   output axi_len_t        wr_len_sh,
   output vwrite_int_t     wr_int_addr_sh,
   output iter_t           wr_iter_a_sh
);

   localparam int RD_MSB = $bits(vread_int_t) - 1;
   localparam int WR_MSB = $bits(vwrite_int_t) - 1;

   // vwrite pipeline two stages ahead of the shadow
   stage_addr_bus_t wr_stage_addr_pip0, wr_stage_addr_pip1;
   axi_len_t        wr_len_pip0, wr_len_pip1;
   vwrite_int_t     wr_int_addr_pip0, wr_int_addr_pip1;
   iter_t           wr_iter_a_pip0, wr_iter_a_pip1;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_stage_addr_sh <= '0;
         rd_len_sh        <= '0;
         rd_int_addr_sh   <= '0;
         rd_iter_a_sh     <= '0;
      end else if (run) begin
         rd_stage_addr_sh <= rd_stage_addr;
         rd_len_sh        <= rd_len;
         rd_iter_a_sh     <= rd_iter_a;
         // flip buffer half only for a nonzero live iteration count
         rd_int_addr_sh   <= rd_pp ?
                             {rd_int_addr_sh[RD_MSB] ^ (|rd_iter_a), rd_int_addr[RD_MSB-1:0]} :
                             rd_int_addr;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_stage_addr_pip0 <= '0;
         wr_stage_addr_pip1 <= '0;
         wr_stage_addr_sh   <= '0;
         wr_len_pip0        <= '0;
         wr_len_pip1        <= '0;
         wr_len_sh          <= '0;
         wr_int_addr_pip0   <= '0;
         wr_int_addr_pip1   <= '0;
         wr_int_addr_sh     <= '0;
         wr_iter_a_pip0     <= '0;
         wr_iter_a_pip1     <= '0;
         wr_iter_a_sh       <= '0;
      end else if (run) begin
         wr_stage_addr_pip0 <= wr_stage_addr;
         wr_stage_addr_pip1 <= wr_stage_addr_pip0;
         wr_stage_addr_sh   <= wr_stage_addr_pip1;
         wr_len_pip0        <= wr_len;
         wr_len_pip1        <= wr_len_pip0;
         wr_len_sh          <= wr_len_pip1;
         // ping-pong follows the config already in pip0
         wr_int_addr_pip0   <= {wr_int_addr_pip0[WR_MSB] ^ (|wr_iter_a_pip0),
                                wr_int_addr[WR_MSB-1:0]};
         wr_int_addr_pip1   <= wr_int_addr_pip0;
         wr_int_addr_sh     <= wr_int_addr_pip1;
         wr_iter_a_pip0     <= wr_iter_a;
         wr_iter_a_pip1     <= wr_iter_a_pip0;
         wr_iter_a_sh       <= wr_iter_a_pip1;
      end
   end

   a_run_single: assert property (@(posedge clk) disable iff (rst) run |=> !run);

endmodule

//--- stage_addr_gen.sv
`timescale 1ns/1ps
`include "yolo_write_settings.svh"

module stage_addr_gen
   import yolo_mem_pkg::*;
#(
   parameter int N_STAGES = `N_STAGES
) (
   input  logic            clk,
   input  logic            rst,
   input  io_addr_t        base,
   input  io_half_t        offset,
   output stage_addr_bus_t stage_addr
);

   localparam int W = `IO_ADDR_W;
   // delay after the add stage to reach the full latency
   localparam int TAIL = `MUL_LAT - 3;

   if (N_STAGES < 2 || TAIL < 1 || N_STAGES * W != $bits(stage_addr_bus_t)) begin : g_check
      $error("stage_addr_gen: unsupported stage count or latency");
   end

   // operand registers shared by all stages
   io_addr_t base_q;
   io_addr_t base_qq;
   io_half_t offset_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         base_q   <= '0;
         base_qq  <= '0;
         offset_q <= '0;
      end else begin
         base_q   <= base;
         base_qq  <= base_q;
         offset_q <= offset;
      end
   end

   // stage 0 is the base itself
   assign stage_addr[W-1:0] = base;

   for (genvar i = 1; i < N_STAGES; i++) begin : g_stage
      io_addr_t prod_q;
      io_addr_t sum_q;
      io_addr_t tail_q [TAIL];

      always_ff @(posedge clk or posedge rst) begin
         if (rst) begin
            prod_q <= '0;
            sum_q  <= '0;
            for (int k = 0; k < TAIL; k++) begin
               tail_q[k] <= '0;
            end
         end else begin
            prod_q    <= io_addr_t'(offset_q) * io_addr_t'(i);
            sum_q     <= base_qq + prod_q;
            tail_q[0] <= sum_q;
            for (int k = 1; k < TAIL; k++) begin
               tail_q[k] <= tail_q[k-1];
            end
         end
      end

      assign stage_addr[i*W +: W] = tail_q[TAIL-1];
   end

endmodule

//--- yolo_cfg_regs.sv
`timescale 1ns/1ps
`include "yolo_write_settings.svh"

module yolo_cfg_regs
   import yolo_cfg_pkg::*;
   import yolo_mem_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        clear,
   input  logic        valid,
   input  cfg_addr_t   addr,
   input  io_addr_t    wdata,
   input  logic        wstrb,
   output io_addr_t    vread_ext_addr,
   output io_half_t    vread_offset,
   output logic        vread_pp,
   output io_half_t    vread_len,
   output vread_int_t  vread_int_addr,
   output iter_t       vread_iter_a,
   output io_addr_t    vwrite_ext_addr,
   output io_half_t    vwrite_offset,
   output axi_len_t    vwrite_len,
   output vwrite_int_t vwrite_int_addr,
   output iter_t       vwrite_iter_a
);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vread_ext_addr  <= '0;
         vread_offset    <= '0;
         vread_pp        <= 1'b0;
         vread_len       <= '0;
         vread_int_addr  <= '0;
         vread_iter_a    <= '0;
         vwrite_ext_addr <= '0;
         vwrite_offset   <= '0;
         vwrite_len      <= '0;
         vwrite_int_addr <= '0;
         vwrite_iter_a   <= '0;
      end else if (clear) begin
         vread_ext_addr  <= '0;
         vread_offset    <= '0;
         vread_pp        <= 1'b0;
         vread_len       <= '0;
         vread_int_addr  <= '0;
         vread_iter_a    <= '0;
         vwrite_ext_addr <= '0;
         vwrite_offset   <= '0;
         vwrite_len      <= '0;
         vwrite_int_addr <= '0;
         vwrite_iter_a   <= '0;
      end else if (valid && wstrb) begin
         // fields take the low bits of wdata
         case (addr)
            `REG_VREAD_EXT_ADDR:  vread_ext_addr  <= wdata;
            `REG_VREAD_OFFSET:    vread_offset    <= io_half_t'(wdata);
            `REG_VREAD_PP:        vread_pp        <= wdata[0];
            `REG_VREAD_LEN:       vread_len       <= io_half_t'(wdata);
            `REG_VREAD_INT_ADDR:  vread_int_addr  <= vread_int_t'(wdata);
            `REG_VREAD_ITER_A:    vread_iter_a    <= iter_t'(wdata);
            `REG_VWRITE_EXT_ADDR: vwrite_ext_addr <= wdata;
            `REG_VWRITE_OFFSET:   vwrite_offset   <= io_half_t'(wdata);
            `REG_VWRITE_LEN:      vwrite_len      <= axi_len_t'(wdata);
            `REG_VWRITE_INT_ADDR: vwrite_int_addr <= vwrite_int_t'(wdata);
            `REG_VWRITE_ITER_A:   vwrite_iter_a   <= iter_t'(wdata);
            default: ;
         endcase
      end
   end

   a_addr_known: assert property (@(posedge clk) disable iff (rst) valid |-> !$isunknown(addr));

endmodule

//--- yolo_mem_pkg.sv
`include "yolo_write_settings.svh"

package yolo_mem_pkg;

   // external address and cpu write data
   typedef logic [`IO_ADDR_W-1:0] io_addr_t;

   // stage offset and vread length in words
   typedef logic [`IO_ADDR_W/2-1:0] io_half_t;

   // axi burst length field
   typedef logic [`AXI_LEN_W-1:0] axi_len_t;

   // one external address per stage with stage 0 in the low bits
   typedef logic [`N_STAGES*`IO_ADDR_W-1:0] stage_addr_bus_t;

endpackage

//--- yolo_cfg_pkg.sv
`include "yolo_write_settings.svh"

package yolo_cfg_pkg;

   // cpu register address
   typedef logic [`CFG_ADDR_W-1:0] cfg_addr_t;

   // internal buffer addresses whose top bit selects the ping-pong half
   typedef logic [`VREAD_INT_W-1:0] vread_int_t;
   typedef logic [`VWRITE_INT_W-1:0] vwrite_int_t;

   // outer loop iteration count
   typedef logic [`ITER_W-1:0] iter_t;

endpackage

//--- yolo_write_settings.svh
`ifndef YOLO_WRITE_SETTINGS_SVH
`define YOLO_WRITE_SETTINGS_SVH

// bus and field widths
`define IO_ADDR_W    32
`define AXI_LEN_W    8
`define CFG_ADDR_W   4
`define VREAD_INT_W  10
`define VWRITE_INT_W 10
`define ITER_W       11

// parallel stages and multiply-add pipeline depth
`define N_STAGES     4
`define MUL_LAT      4

// cpu register map
`define REG_VREAD_EXT_ADDR   0
`define REG_VREAD_OFFSET     1
`define REG_VREAD_PP         2
`define REG_VREAD_LEN        3
`define REG_VREAD_INT_ADDR   4
`define REG_VREAD_ITER_A     5
`define REG_VWRITE_EXT_ADDR  6
`define REG_VWRITE_OFFSET    7
`define REG_VWRITE_LEN       8
`define REG_VWRITE_INT_ADDR  9
`define REG_VWRITE_ITER_A    10

`endif
